// ==== logic/nocArbPkg.sv ====
`default_nettype none

package nocArbPkg;

  // Router ports, in round-robin order.
  localparam int numPorts = 5;

  typedef enum logic [2:0] {
    portLocal = 3'd0,
    portNorth = 3'd1,
    portEast  = 3'd2,
    portWest  = 3'd3,
    portSouth = 3'd4
  } portId_t;

  // One-hot grant. Bit 0 is idle, bit p+1 grants port p.
  typedef logic [numPorts:0] grantState_t;

  localparam grantState_t grantIdle = 6'b000001;

  // Grant timeout counts.
  localparam int timerWidth = 12;

  typedef logic [timerWidth-1:0] timerCount_t;

endpackage

`default_nettype wire

// ==== logic/nocFlitPkg.sv ====
`default_nettype none

package nocFlitPkg;

  import nocArbPkg::*;

  typedef enum logic [2:0] {
    kindHeader = 3'b001,
    kindBody   = 3'b010,
    kindTail   = 3'b100
  } flitKind_t;

  localparam int lengthWidth = 12;
  localparam int infoWidth   = 29;
  localparam int routeWidth  = infoWidth - lengthWidth;

  // Header view. Length is the grant timeout for the packet.
  typedef struct packed {
    logic [lengthWidth-1:0] length;
    logic [routeWidth-1:0]  routeTag;
  } flitHeader_t;

  typedef struct packed {
    logic [infoWidth-1:0] payload;
  } flitBody_t;

  // Same bits, read by kind.
  typedef union packed {
    flitHeader_t header;
    flitBody_t   body;
  } flitInfo_u;

  typedef struct packed {
    flitKind_t kind;
    flitInfo_u info;
  } flit_t;

  // Output flit, tagged with the input it came from.
  typedef struct packed {
    portId_t source;
    flit_t   flit;
  } taggedFlit_t;

endpackage

`default_nettype wire

// ==== logic/inputBuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module inputBuffer
  import nocArbPkg::*;
  import nocFlitPkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  flit_t       inFlit,
  input  logic        inValid,
  output logic        inReady,
  input  logic        pop,
  output flit_t       bufFlit,
  output logic        bufValid,
  output timerCount_t limit
);

  logic full;
  logic push;

  // A full slot still takes a flit when it drains on the same edge.
  assign inReady  = !full || pop;
  assign push     = inValid && inReady;
  assign bufValid = full;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      full <= 1'b0;
    end
    else if (push)
    begin
      full <= 1'b1;
    end
    else if (pop)
    begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      bufFlit <= inFlit;
    end
  end

  // Header flits carry this port's grant timeout.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
    end
    else if (push && inFlit.kind == kindHeader)
    begin
      limit <= inFlit.info.header.length;
    end
  end

endmodule

`default_nettype wire

// ==== logic/grantTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

module grantTimer
  import nocArbPkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        runTimer,
  input  timerCount_t limit,
  output logic        timesUp
);

  timerCount_t count;

  // Cycles held in the current grant. Any cycle not held restarts it.
  always_ff @(posedge clk)
  begin
    if (rst || !runTimer)
    begin
      count <= '0;
    end
    else
    begin
      count <= count + 1'b1;
    end
  end

  // Count starts at zero on the first granted cycle,
  // so a grant spans at most limit+1 cycles.
  assign timesUp = (count == limit);

endmodule

`default_nettype wire

// ==== logic/portArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module portArbiter
  import nocArbPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [numPorts-1:0] request,
  input  logic                timesUp,
  input  logic                pop,
  output grantState_t         grant,
  output logic                runTimer
);

  grantState_t         nextGrant;
  logic [numPorts-1:0] portGrant;
  logic                reqHeld;
  logic                keep;
  logic                stalled;
  int                  curPort;

  //////////////////////////////////////////////////////////////////////
  // Hold conditions.
  //////////////////////////////////////////////////////////////////////

  assign portGrant = grant[numPorts:1];
  assign reqHeld   = |(portGrant & request);
  assign keep      = reqHeld && !timesUp;

  // Granted flit waiting on a full output slot.
  assign stalled   = reqHeld && !pop;

  assign runTimer  = keep;

  always_comb
  begin
    curPort = 0;
    for (int p = 0; p < numPorts; p++)
    begin
      if (portGrant[p])
      begin
        curPort = p;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Next grant.
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    int idx;

    idx       = 0;
    nextGrant = grantIdle;
    if (grant[0])
    begin
      // Lowest numbered requester wins from idle.
      for (int p = numPorts - 1; p >= 0; p--)
      begin
        if (request[p])
        begin
          nextGrant        = '0;
          nextGrant[p + 1] = 1'b1;
        end
      end
    end
    else if (keep || stalled)
    begin
      nextGrant = grant;
    end
    else
    begin
      // Round-robin, starting after the current port and skipping it.
      for (int k = numPorts - 1; k >= 1; k--)
      begin
        idx = curPort + k;
        if (idx >= numPorts)
        begin
          idx = idx - numPorts;
        end
        if (request[idx])
        begin
          nextGrant          = '0;
          nextGrant[idx + 1] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= grantIdle;
    end
    else
    begin
      grant <= nextGrant;
    end
  end

endmodule

`default_nettype wire

// ==== logic/outputStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module outputStage
  import nocArbPkg::*;
  import nocFlitPkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  grantState_t                grant,
  input  flit_t [numPorts-1:0]       bufFlit,
  input  logic [numPorts-1:0]        bufValid,
  output logic [numPorts-1:0]        pop,
  output taggedFlit_t                outFlit,
  output logic                       outValid,
  input  logic                       outReady
);

  flit_t   selFlit;
  portId_t selPort;
  logic    selValid;
  logic    slotFree;
  logic    take;

  always_comb
  begin
    selValid = 1'b0;
    selFlit  = bufFlit[0];
    selPort  = portLocal;
    for (int p = 0; p < numPorts; p++)
    begin
      if (grant[p + 1])
      begin
        selValid = bufValid[p];
        selFlit  = bufFlit[p];
        selPort  = portId_t'(p);
      end
    end
  end

  // Slot is free when empty or draining this cycle.
  assign slotFree = !outValid || outReady;
  assign take     = selValid && slotFree;
  assign pop      = take ? grant[numPorts:1] : '0;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else if (slotFree)
    begin
      outValid <= take;
    end
  end

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      outFlit.source <= selPort;
      outFlit.flit   <= selFlit;
    end
  end

endmodule

`default_nettype wire

// ==== logic/outputPortTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module outputPortTop
  import nocArbPkg::*;
  import nocFlitPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  flit_t [numPorts-1:0] inFlit,
  input  logic [numPorts-1:0]  inValid,
  output logic [numPorts-1:0]  inReady,
  output taggedFlit_t          outFlit,
  output logic                 outValid,
  input  logic                 outReady
);

  flit_t [numPorts-1:0]       bufFlit;
  logic [numPorts-1:0]        bufValid;
  logic [numPorts-1:0]        pop;
  timerCount_t [numPorts-1:0] limit;
  timerCount_t                grantLimit;
  grantState_t                grant;
  logic                       runTimer;
  logic                       timesUp;

  //////////////////////////////////////////////////////////////////////
  // Input buffers.
  //////////////////////////////////////////////////////////////////////

  for (genvar p = 0; p < numPorts; p++)
  begin : inBuf
    inputBuffer buffer (
      .clk      (clk),
      .rst      (rst),
      .inFlit   (inFlit[p]),
      .inValid  (inValid[p]),
      .inReady  (inReady[p]),
      .pop      (pop[p]),
      .bufFlit  (bufFlit[p]),
      .bufValid (bufValid[p]),
      .limit    (limit[p])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Arbitration and grant timeout.
  //////////////////////////////////////////////////////////////////////

  portArbiter arbiter (
    .clk      (clk),
    .rst      (rst),
    .request  (bufValid),
    .timesUp  (timesUp),
    .pop      (|pop),
    .grant    (grant),
    .runTimer (runTimer)
  );

  // Timeout of whichever port holds the grant.
  always_comb
  begin
    grantLimit = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      if (grant[p + 1])
      begin
        grantLimit = limit[p];
      end
    end
  end

  grantTimer timer (
    .clk      (clk),
    .rst      (rst),
    .runTimer (runTimer),
    .limit    (grantLimit),
    .timesUp  (timesUp)
  );

  outputStage outStage (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .bufFlit  (bufFlit),
    .bufValid (bufValid),
    .pop      (pop),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outReady (outReady)
  );

endmodule

`default_nettype wire

// ==== verif/outputPortTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module outputPortTb
  import nocArbPkg::*;
  import nocFlitPkg::*;
();

  localparam int packetsPerPort = 25;
  localparam int waitLimit      = 20000;

  logic                 clk;
  logic                 rst;
  flit_t [numPorts-1:0] inFlit;
  logic [numPorts-1:0]  inValid;
  logic [numPorts-1:0]  inReady;
  taggedFlit_t          outFlit;
  logic                 outValid;
  logic                 outReady;

  flit_t       modelQ[numPorts][$];
  int          lastLen[numPorts];
  int          pktsLeft[numPorts];
  int          flitsLeft[numPorts];
  logic [numPorts-1:0] fired;
  logic        running;
  logic        allSent;
  logic        holdPending;
  taggedFlit_t heldFlit;
  logic        prevOutFire;
  int          runSrc;
  int          runLen;
  logic [numPorts-1:0] runMask;
  int          inCount;
  int          outCount;
  int          checkCount;
  int          errorCount;

  outputPortTop UUT (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inValid  (inValid),
    .inReady  (inReady),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outReady (outReady)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks.
  //////////////////////////////////////////////////////////////////////

  task automatic checkFlit(input string name, input flit_t got, input flit_t exp);
    checkCount++;
    if (got.kind !== exp.kind || got.info.header !== exp.info.header ||
        got.info.body !== exp.info.body)
    begin
      errorCount++;
      $display("FAILED %s: got %h expected %h (kind %h/%h, payload %h/%h)", name, got, exp,
               got.kind, exp.kind, got.info.body.payload, exp.info.body.payload);
    end
  endtask

  task automatic checkSource(input string name, input portId_t got, input portId_t exp);
    checkCount++;
    if (got !== exp)
    begin
      errorCount++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  function automatic flit_t makeFlit(input flitKind_t kind, input int len);
    flit_t       f;
    logic [31:0] r;

    r = $urandom;
    f.kind = kind;
    f.info.body.payload = r[infoWidth-1:0];
    if (kind == kindHeader)
    begin
      f.info.header.length = lengthWidth'(len);
    end
    return f;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus. A new packet waits until its port has fully drained.
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    #1;
    if (running)
    begin
      outReady = ($urandom % 10) < 7;
      for (int p = 0; p < numPorts; p++)
      begin
        if (!inValid[p] || fired[p])
        begin
          inValid[p] = 1'b0;
          if (flitsLeft[p] > 0 && $urandom % 4 != 0)
          begin
            inFlit[p]  = makeFlit(flitsLeft[p] == 1 ? kindTail : kindBody, 0);
            inValid[p] = 1'b1;
            flitsLeft[p]--;
          end
          else if (flitsLeft[p] == 0 && pktsLeft[p] > 0 && modelQ[p].size() == 0 &&
                   $urandom % 3 == 0)
          begin
            inFlit[p]    = makeFlit(kindHeader, int'($urandom % 8));
            inValid[p]   = 1'b1;
            flitsLeft[p] = int'($urandom % 4) + 1;
            pktsLeft[p]--;
          end
        end
      end
      allSent = 1'b1;
      for (int p = 0; p < numPorts; p++)
      begin
        if (inValid[p] || flitsLeft[p] > 0 || pktsLeft[p] > 0)
        begin
          allSent = 1'b0;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Monitor, sampled mid-cycle where all signals are settled.
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    int                  src;
    logic [numPorts-1:0] blocked;
    logic                wasStalled;
    flit_t               exp;

    if (!rst)
    begin
      blocked = '0;
      for (int p = 0; p < numPorts; p++)
      begin
        fired[p] = inValid[p] && inReady[p];
        blocked[p] = inValid[p] && !inReady[p];
        if (fired[p])
        begin
          modelQ[p].push_back(inFlit[p]);
          inCount++;
          if (inFlit[p].kind == kindHeader)
          begin
            lastLen[p] = int'(inFlit[p].info.header.length);
          end
        end
      end
      if (holdPending)
      begin
        checkFlit("outFlit.flit under back-pressure", outFlit.flit, heldFlit.flit);
        checkSource("outFlit.source under back-pressure", outFlit.source, heldFlit.source);
      end
      wasStalled  = holdPending;
      holdPending = outValid && !outReady;
      heldFlit    = outFlit;
      if (outValid && outReady)
      begin
        outCount++;
        src = int'(outFlit.source);
        if (src >= numPorts || modelQ[src].size() == 0)
        begin
          errorCount++;
          $display("Output flit from source %0d was never sent by that port", src);
        end
        else
        begin
          exp = modelQ[src].pop_front();
          checkFlit("outFlit.flit", outFlit.flit, exp);
          blocked[src] = 1'b0;
          if (prevOutFire && src == runSrc)
          begin
            runLen++;
            runMask = runMask & blocked;
          end
          else
          begin
            runSrc  = src;
            runLen  = 1;
            // After a stall the first flit was taken before this grant window.
            runMask = wasStalled ? '0 : blocked;
          end
          if (runMask != '0 && runLen > lastLen[src] + 1)
          begin
            errorCount++;
            $display("Source %0d kept the output for %0d flits with a timeout of %0d",
                     src, runLen, lastLen[src]);
          end
        end
      end
      prevOutFire = outValid && outReady;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence.
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int   cycles;
    int   errBefore;
    int   pending;
    logic timedOut;

    void'($urandom(32'h426a_3e84));
    rst = 1'b1;
    inFlit = '0;
    inValid = '0;
    outReady = 1'b0;
    running = 1'b0;
    allSent = 1'b0;
    fired = '0;
    holdPending = 1'b0;
    heldFlit = '0;
    prevOutFire = 1'b0;
    runSrc = 0;
    runLen = 0;
    runMask = '0;
    inCount = 0;
    outCount = 0;
    checkCount = 0;
    errorCount = 0;
    timedOut = 1'b0;
    for (int p = 0; p < numPorts; p++)
    begin
      lastLen[p] = 0;
      pktsLeft[p] = packetsPerPort;
      flitsLeft[p] = 0;
    end
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;

    @(negedge clk);
    errBefore = errorCount;
    checkCount++;
    if (outValid !== 1'b0)
    begin
      errorCount++;
      $display("FAILED outValid: got %h expected %h", outValid, 1'b0);
    end
    checkCount++;
    if (inReady !== '1)
    begin
      errorCount++;
      $display("FAILED inReady: got %h expected %h", inReady, {numPorts{1'b1}});
    end
    $display("Test reset state: %0d errors", errorCount - errBefore);

    errBefore = errorCount;
    running = 1'b1;
    cycles = 0;
    while (!allSent && cycles < waitLimit)
    begin
      @(posedge clk);
      cycles++;
    end
    if (!allSent)
    begin
      timedOut = 1'b1;
      $display("Timeout while the input ports were still sending");
    end
    $display("Test random traffic: %0d flits in, %0d errors", inCount, errorCount - errBefore);

    if (!timedOut)
    begin
      errBefore = errorCount;
      cycles = 0;
      pending = 1;
      while (pending != 0 && cycles < waitLimit)
      begin
        @(negedge clk);
        cycles++;
        pending = 0;
        for (int p = 0; p < numPorts; p++)
        begin
          pending = pending + modelQ[p].size();
        end
      end
      if (pending != 0)
      begin
        timedOut = 1'b1;
        $display("Timeout while draining, %0d flits never came out", pending);
      end
      checkCount++;
      if (inCount != outCount)
      begin
        errorCount++;
        $display("Sent %0d flits but received %0d", inCount, outCount);
      end
      $display("Test drain: %0d flits out, %0d errors", outCount, errorCount - errBefore);
    end

    $display("Tests 3, checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0 && !timedOut)
    begin
      $display("Testbench passed");
    end
    else
    begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/nocArbPkg.sv
logic/nocFlitPkg.sv
logic/inputBuffer.sv
logic/grantTimer.sv
logic/portArbiter.sv
logic/outputStage.sv
logic/outputPortTop.sv
verif/outputPortTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= compile.f
TB_TOP    ?= outputPortTb
RTL_TOP   ?= outputPortTop
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Testbench passed
SIM_FLAGS ?= --binary --timing

RTL_FILES := $(filter logic/%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_FILES)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o simv
	$(BUILD_DIR)/simv | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
